// ==== hdl/mbesm_uword_pkg.sv ====
`default_nettype none

package mbesm_uword_pkg;

    //----------------------------------------------------------------------
    // Control store and sequencer sizes
    //----------------------------------------------------------------------
    localparam int UADDR_W     = 8;                 // Microaddress width
    localparam int USTORE_N    = 1 << UADDR_W;      // Control store words
    localparam int STACK_DEPTH = 4;                 // Subroutine stack depth
    localparam int SP_W        = 3;                 // Stack pointer, 0..STACK_DEPTH
    localparam int LIT_W       = 16;                // Literal field
    localparam int UWORD_W     = 64;                // Whole microword
    localparam int PAD_W       = UWORD_W - 52;      // Unused low bits

    typedef enum logic [2:0] {
        SEQ_CONT = 3'd0,                            // Continue, reset value
        SEQ_JZ   = 3'd1,                            // Jump to zero, clear stack
        SEQ_CJP  = 3'd2,                            // Conditional jump
        SEQ_CJS  = 3'd3,                            // Conditional call
        SEQ_CRTN = 3'd4                             // Conditional return
    } seq_op_e;

    typedef enum logic [2:0] {
        COND_ALWAYS = 3'd0,
        COND_ZERO   = 3'd1,
        COND_NEG    = 3'd2,
        COND_CARRY  = 3'd3,
        COND_TR0    = 3'd4,
        COND_TR1    = 3'd5
    } cond_sel_e;

    typedef enum logic [1:0] {
        DSRC_LIT   = 2'd0,                          // Zero-extended literal
        DSRC_UREG  = 2'd1,                          // Effective-address register
        DSRC_SHIFT = 2'd2,                          // Shift result
        DSRC_FLAGS = 2'd3                           // Flag word
    } dsrc_e;

    typedef enum logic [2:0] {
        YD_NONE   = 3'd0,
        YD_REG    = 3'd1,                           // Register RB
        YD_UREG   = 3'd2,
        YD_PSHIFT = 3'd3,
        YD_SHIFT  = 3'd4,
        YD_OUT    = 3'd5,
        YD_HALT   = 3'd6
    } ydst_e;

    typedef enum logic [1:0] {
        FF_KEEP    = 2'd0,
        FF_SET_TR0 = 2'd1,
        FF_SET_TR1 = 2'd2,
        FF_CLR_ALL = 2'd3
    } ff_op_e;

    typedef enum logic [1:0] {
        CIN_ZERO = 2'd0,
        CIN_ONE  = 2'd1,
        CIN_COND = 2'd2                             // Condition from sequencer
    } cin_sel_e;

    // Microword layout, MSB first
    typedef struct packed {
        seq_op_e              seq_op;               // 63:61
        logic [UADDR_W-1:0]   br_addr;              // 60:53
        cond_sel_e            cond_sel;             // 52:50
        logic                 cond_inv;             // 49
        logic [2:0]           alu_op;               // 48:46, ALU function code
        cin_sel_e             cin_sel;              // 45:44
        logic [3:0]           ra;                   // 43:40
        logic [3:0]           rb;                   // 39:36
        dsrc_e                dsrc;                 // 35:34
        ydst_e                ydst;                 // 33:31
        logic                 flag_en;              // 30
        ff_op_e               ff_op;                // 29:28
        logic [LIT_W-1:0]     lit;                  // 27:12
        logic [PAD_W-1:0]     pad;                  // 11:0
    } uword_t;

endpackage

`default_nettype wire

// ==== hdl/mbesm_data_pkg.sv ====
`default_nettype none

package mbesm_data_pkg;

    localparam int DATA_W  = 64;                    // Datapath width
    localparam int REG_N   = 16;                    // Register file depth
    localparam int SHAMT_W = 7;                     // Top bit set means left

    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0,                           // A + D + cin
        ALU_SUB   = 3'd1,                           // A + ~D + cin
        ALU_AND   = 3'd2,
        ALU_OR    = 3'd3,
        ALU_XOR   = 3'd4,
        ALU_PASSD = 3'd5,
        ALU_PASSA = 3'd6,
        ALU_NOTA  = 3'd7
    } alu_op_e;

    // Flag word, also readable on D in bits 2:0
    typedef struct packed {
        logic zero;                                 // Bit 2
        logic negative;                             // Bit 1
        logic carry;                                // Bit 0
    } flags_t;

endpackage

`default_nettype wire

// ==== hdl/mbesm_uinstr_decode.sv ====
`default_nettype none

module mbesm_uinstr_decode (
    input  wire                                      clk,
    input  wire                                      reset,
    input  wire                                      i_load_we,      // Control store write
    input  wire  [mbesm_uword_pkg::UADDR_W-1:0]      i_load_addr,
    input  mbesm_uword_pkg::uword_t                  i_load_word,
    input  wire                                      i_step,         // Core advances
    input  wire  [mbesm_uword_pkg::UADDR_W-1:0]      i_uaddr,        // Next word to fetch
    output mbesm_uword_pkg::uword_t                  o_uw            // Pipeline register
);

    //----------------------------------------------------------------------
    // Writable control store
    //----------------------------------------------------------------------
    mbesm_uword_pkg::uword_t ustore [mbesm_uword_pkg::USTORE_N];

    always_ff @(posedge clk) begin
        if (i_load_we) begin
            ustore[i_load_addr] <= i_load_word;     // Only while stopped
        end
    end

    //----------------------------------------------------------------------
    // Pipeline register
    //----------------------------------------------------------------------
    // The word stays in place while stopped, so the next address computed
    // from it does not move until the core steps again.
    always_ff @(posedge clk) begin
        if (reset) begin
            o_uw <= '0;                             // CONT, no destination
        end else if (i_step) begin
            o_uw <= ustore[i_uaddr];                // Executes next cycle
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mbesm_sequencer.sv ====
`default_nettype none

module mbesm_sequencer (
    input  wire                                      clk,
    input  wire                                      reset,
    input  mbesm_uword_pkg::uword_t                  i_uw,           // Word now executing
    input  wire                                      i_step,
    input  mbesm_data_pkg::flags_t                   i_flags,        // Registered ALU flags
    input  wire                                      i_tr0,
    input  wire                                      i_tr1,
    output logic [mbesm_uword_pkg::UADDR_W-1:0]      o_uaddr,        // Address to fetch
    output logic                                     o_cond          // After invert
);

    localparam int AW = mbesm_uword_pkg::UADDR_W;
    localparam int SW = mbesm_uword_pkg::SP_W;

    logic [AW-1:0] upc;                             // Executing word address + 1
    logic [SW-1:0] sp;                              // Number of live entries
    logic [SW-1:0] sp_top;                          // Index of top entry
    logic [AW-1:0] stack [mbesm_uword_pkg::STACK_DEPTH];
    logic [AW-1:0] ret_addr;
    logic          cond_raw;

    //----------------------------------------------------------------------
    // Condition multiplexer
    //----------------------------------------------------------------------
    always_comb begin
        case (i_uw.cond_sel)
            mbesm_uword_pkg::COND_ALWAYS: cond_raw = 1'b1;
            mbesm_uword_pkg::COND_ZERO:   cond_raw = i_flags.zero;
            mbesm_uword_pkg::COND_NEG:    cond_raw = i_flags.negative;
            mbesm_uword_pkg::COND_CARRY:  cond_raw = i_flags.carry;
            mbesm_uword_pkg::COND_TR0:    cond_raw = i_tr0;
            mbesm_uword_pkg::COND_TR1:    cond_raw = i_tr1;
            default:                      cond_raw = 1'b0;    // Unused codes
        endcase
    end

    assign o_cond = cond_raw ^ i_uw.cond_inv;

    //----------------------------------------------------------------------
    // Next address
    //----------------------------------------------------------------------
    assign sp_top   = sp - 1'b1;
    assign ret_addr = (sp == '0) ? '0 : stack[sp_top[SW-2:0]];    // Empty pops to 0

    always_comb begin
        case (i_uw.seq_op)
            mbesm_uword_pkg::SEQ_JZ:   o_uaddr = '0;
            mbesm_uword_pkg::SEQ_CJP,
            mbesm_uword_pkg::SEQ_CJS:  o_uaddr = o_cond ? i_uw.br_addr : upc;
            mbesm_uword_pkg::SEQ_CRTN: o_uaddr = o_cond ? ret_addr : upc;
            default:                   o_uaddr = upc;             // CONT
        endcase
    end

    //----------------------------------------------------------------------
    // Counter and stack pointer
    //----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            upc <= '0;                              // First fetch from 0
            sp  <= '0;
        end else if (i_step) begin
            upc <= o_uaddr + 1'b1;
            case (i_uw.seq_op)
                mbesm_uword_pkg::SEQ_JZ:   sp <= '0;
                mbesm_uword_pkg::SEQ_CJS:  if (o_cond) sp <= sp + 1'b1;
                mbesm_uword_pkg::SEQ_CRTN: if (o_cond && sp != '0) sp <= sp - 1'b1;
                default: ;
            endcase
        end
    end

    // Push the return address, the word after the call
    always_ff @(posedge clk) begin
        if (i_step && o_cond && i_uw.seq_op == mbesm_uword_pkg::SEQ_CJS) begin
            stack[sp[SW-2:0]] <= upc;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mbesm_execute.sv ====
`default_nettype none

module mbesm_execute (
    input  wire                                      clk,
    input  wire                                      reset,
    input  mbesm_uword_pkg::uword_t                  i_uw,
    input  wire                                      i_step,
    input  wire                                      i_cond,         // For carry-in
    input  wire  [mbesm_data_pkg::DATA_W-1:0]        i_ureg,         // Effective address
    input  wire  [mbesm_data_pkg::DATA_W-1:0]        i_shift,        // Shift result
    output logic [mbesm_data_pkg::DATA_W-1:0]        o_y,            // Y bus
    output mbesm_data_pkg::flags_t                   o_flags         // Flag register
);

    localparam int DW = mbesm_data_pkg::DATA_W;

    logic [DW-1:0]          rf [mbesm_data_pkg::REG_N];
    logic [DW-1:0]          a_bus;
    logic [DW-1:0]          d_bus;
    logic                   cin;
    logic                   carry_out;
    mbesm_data_pkg::alu_op_e alu_op;
    mbesm_data_pkg::flags_t  flags_next;

    //----------------------------------------------------------------------
    // Operand selection
    //----------------------------------------------------------------------
    assign a_bus  = rf[i_uw.ra];
    assign alu_op = mbesm_data_pkg::alu_op_e'(i_uw.alu_op);

    always_comb begin
        case (i_uw.dsrc)
            mbesm_uword_pkg::DSRC_LIT:   d_bus = DW'(i_uw.lit);        // Zero-extended
            mbesm_uword_pkg::DSRC_UREG:  d_bus = i_ureg;
            mbesm_uword_pkg::DSRC_SHIFT: d_bus = i_shift;
            default:                     d_bus = DW'(o_flags);         // Z,N,C in 2:0
        endcase
    end

    always_comb begin
        case (i_uw.cin_sel)
            mbesm_uword_pkg::CIN_ONE:  cin = 1'b1;
            mbesm_uword_pkg::CIN_COND: cin = i_cond;
            default:                   cin = 1'b0;
        endcase
    end

    //----------------------------------------------------------------------
    // ALU
    //----------------------------------------------------------------------
    always_comb begin
        carry_out = 1'b0;                           // Logic ops clear carry
        case (alu_op)
            mbesm_data_pkg::ALU_ADD:   {carry_out, o_y} = {1'b0, a_bus} + {1'b0, d_bus} + cin;
            mbesm_data_pkg::ALU_SUB:   {carry_out, o_y} = {1'b0, a_bus} + {1'b0, ~d_bus} + cin;
            mbesm_data_pkg::ALU_AND:   o_y = a_bus & d_bus;
            mbesm_data_pkg::ALU_OR:    o_y = a_bus | d_bus;
            mbesm_data_pkg::ALU_XOR:   o_y = a_bus ^ d_bus;
            mbesm_data_pkg::ALU_PASSD: o_y = d_bus;
            mbesm_data_pkg::ALU_PASSA: o_y = a_bus;
            default:                   o_y = ~a_bus;    // NOTA
        endcase
    end

    assign flags_next.zero     = (o_y == '0);
    assign flags_next.negative = o_y[DW-1];
    assign flags_next.carry    = carry_out;

    //----------------------------------------------------------------------
    // Register file and flags, written at end of cycle
    //----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_step && i_uw.ydst == mbesm_uword_pkg::YD_REG) begin
            rf[i_uw.rb] <= o_y;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_flags <= '0;
        end else if (i_step && i_uw.flag_en) begin
            o_flags <= flags_next;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mbesm_result.sv ====
`default_nettype none

module mbesm_result (
    input  wire                                      clk,
    input  wire                                      reset,
    input  mbesm_uword_pkg::uword_t                  i_uw,
    input  wire                                      i_step,
    input  wire  [mbesm_data_pkg::DATA_W-1:0]        i_y,
    output logic [mbesm_data_pkg::DATA_W-1:0]        o_ureg,         // Effective address
    output logic [mbesm_data_pkg::DATA_W-1:0]        o_shift,        // Shift result
    output logic                                     o_tr0,
    output logic                                     o_tr1,
    output logic                                     o_out_valid,    // One-cycle pulse
    output logic [mbesm_data_pkg::DATA_W-1:0]        o_out_data,
    output logic                                     o_halted        // Sticky
);

    localparam int SHW = mbesm_data_pkg::SHAMT_W;

    logic [SHW-1:0] pshift;                         // Shift parameter
    logic           wr;                             // Destination write this cycle

    assign wr = i_step;

    //----------------------------------------------------------------------
    // Y-bus destination registers
    //----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr) begin
            case (i_uw.ydst)
                mbesm_uword_pkg::YD_UREG:   o_ureg <= i_y;
                mbesm_uword_pkg::YD_PSHIFT: pshift <= i_y[SHW-1:0];
                mbesm_uword_pkg::YD_SHIFT:  o_shift <= pshift[SHW-1] ?
                                                       i_y << pshift[SHW-2:0] :   // Left
                                                       i_y >> pshift[SHW-2:0];    // Right
                mbesm_uword_pkg::YD_OUT:    o_out_data <= i_y;
                default: ;
            endcase
        end
    end

    //----------------------------------------------------------------------
    // Control state
    //----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            o_out_valid <= 1'b0;
            o_halted    <= 1'b0;
            o_tr0       <= 1'b0;
            o_tr1       <= 1'b0;
        end else begin
            o_out_valid <= wr && i_uw.ydst == mbesm_uword_pkg::YD_OUT;
            if (wr && i_uw.ydst == mbesm_uword_pkg::YD_HALT) begin
                o_halted <= 1'b1;                   // Held until reset
            end
            if (wr) begin
                case (i_uw.ff_op)
                    mbesm_uword_pkg::FF_SET_TR0: o_tr0 <= 1'b1;
                    mbesm_uword_pkg::FF_SET_TR1: o_tr1 <= 1'b1;
                    mbesm_uword_pkg::FF_CLR_ALL: begin
                        o_tr0 <= 1'b0;
                        o_tr1 <= 1'b0;
                    end
                    default: ;                      // KEEP
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mbesm_ucore.sv ====
`default_nettype none

module mbesm_ucore (
    input  wire                                      clk,
    input  wire                                      reset,
    input  wire                                      i_load_we,
    input  wire  [mbesm_uword_pkg::UADDR_W-1:0]      i_load_addr,
    input  mbesm_uword_pkg::uword_t                  i_load_word,
    input  wire                                      i_run,          // Level, lets core step
    output logic                                     o_out_valid,
    output logic [mbesm_data_pkg::DATA_W-1:0]        o_out_data,
    output logic                                     o_halted
);

    mbesm_uword_pkg::uword_t                  uw;         // Pipeline register
    logic [mbesm_uword_pkg::UADDR_W-1:0]      uaddr;
    logic                                     cond;
    logic [mbesm_data_pkg::DATA_W-1:0]        y;
    mbesm_data_pkg::flags_t                   flags;
    logic [mbesm_data_pkg::DATA_W-1:0]        ureg;
    logic [mbesm_data_pkg::DATA_W-1:0]        shift_q;
    logic                                     tr0;
    logic                                     tr1;
    logic                                     step;

    assign step = i_run && !o_halted;               // Only place halt is tested

    mbesm_uinstr_decode i_decode (
        .clk         (clk),
        .reset       (reset),
        .i_load_we   (i_load_we),
        .i_load_addr (i_load_addr),
        .i_load_word (i_load_word),
        .i_step      (step),
        .i_uaddr     (uaddr),
        .o_uw        (uw)
    );

    mbesm_sequencer i_sequencer (
        .clk     (clk),
        .reset   (reset),
        .i_uw    (uw),
        .i_step  (step),
        .i_flags (flags),
        .i_tr0   (tr0),
        .i_tr1   (tr1),
        .o_uaddr (uaddr),
        .o_cond  (cond)
    );

    mbesm_execute i_execute (
        .clk     (clk),
        .reset   (reset),
        .i_uw    (uw),
        .i_step  (step),
        .i_cond  (cond),
        .i_ureg  (ureg),
        .i_shift (shift_q),
        .o_y     (y),
        .o_flags (flags)
    );

    mbesm_result i_result (
        .clk         (clk),
        .reset       (reset),
        .i_uw        (uw),
        .i_step      (step),
        .i_y         (y),
        .o_ureg      (ureg),
        .o_shift     (shift_q),
        .o_tr0       (tr0),
        .o_tr1       (tr1),
        .o_out_valid (o_out_valid),
        .o_out_data  (o_out_data),
        .o_halted    (o_halted)
    );

endmodule

`default_nettype wire

// ==== verif/mbesm_ucore_assert.sv ====
`default_nettype none

module mbesm_ucore_assert (
    input wire                                   clk,
    input wire                                   reset,
    input wire                                   i_step,
    input wire [mbesm_uword_pkg::SP_W-1:0]       i_sp,       // Live stack entries
    input wire [mbesm_uword_pkg::UADDR_W-1:0]    i_uaddr     // Next fetch address
);

    int fail_count = 0;                             // Read by testbench at end

    // At most four return addresses on the stack
    sp_in_range: assert property (@(posedge clk) disable iff (reset)
        i_sp <= mbesm_uword_pkg::STACK_DEPTH)
        else begin
            fail_count++;
            $error("stack pointer %0d above stack depth", i_sp);
        end

    // Stopped core keeps pointing at the same word
    addr_holds: assert property (@(posedge clk) disable iff (reset)
        !i_step |=> $stable(i_uaddr))
        else begin
            fail_count++;
            $error("microaddress moved while not stepping");
        end

endmodule

`default_nettype wire

// ==== verif/mbesm_ucore_tb.sv ====
`default_nettype none

module mbesm_ucore_tb;

    localparam int DW       = mbesm_data_pkg::DATA_W;
    localparam int BODY_N   = 40;                   // Random words in main
    localparam int SUB_N    = 10;                   // Words per subroutine
    localparam int MAIN_END = 19 + BODY_N;          // HALT word
    localparam int SUB1     = MAIN_END + 1;         // May call SUB2
    localparam int SUB2     = SUB1 + SUB_N;         // Leaf

    logic                    clk, reset, i_load_we, i_run, o_out_valid, o_halted;
    logic [7:0]              i_load_addr;
    mbesm_uword_pkg::uword_t i_load_word;
    logic [DW-1:0]           o_out_data;
    logic [31:0]             lfsr = 32'd88;
    mbesm_uword_pkg::uword_t prog [mbesm_uword_pkg::USTORE_N];
    logic [DW-1:0]           exp_q [$];             // From the model
    logic [DW-1:0]           got_q [$];             // From the DUT

    mbesm_ucore i_mbesm_ucore (
        .clk         (clk),
        .reset       (reset),
        .i_load_we   (i_load_we),
        .i_load_addr (i_load_addr),
        .i_load_word (i_load_word),
        .i_run       (i_run),
        .o_out_valid (o_out_valid),
        .o_out_data  (o_out_data),
        .o_halted    (o_halted)
    );

    bind mbesm_sequencer mbesm_ucore_assert i_seq_assert (
        .clk     (clk),
        .reset   (reset),
        .i_step  (i_step),
        .i_sp    (sp),
        .i_uaddr (o_uaddr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Fibonacci LFSR x^32+x^22+x^2+x+1, one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_value(input logic [DW-1:0] got, input logic [DW-1:0] want,
                               input string what);
        if (got !== want) begin
            $display("Fail at %0t: %s, got %h expected %h", $time, what, got, want);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    //----------------------------------------------------------------------
    // Program generator
    //----------------------------------------------------------------------
    function automatic mbesm_uword_pkg::uword_t load_word(input logic [3:0] rb,
                                                          input mbesm_uword_pkg::ydst_e yd);
        mbesm_uword_pkg::uword_t w;
        w        = '0;                              // D from literal
        w.alu_op = mbesm_data_pkg::ALU_PASSD;
        w.rb     = rb;
        w.ydst   = yd;
        w.lit    = 16'(rand_bits(16));
        return w;
    endfunction

    // lvl 0 main, 1 outer subroutine, 2 leaf subroutine
    function automatic mbesm_uword_pkg::uword_t body_word(input int a, input int last,
                                                          input int lvl);
        mbesm_uword_pkg::uword_t w;
        logic [2:0]              r;
        w          = mbesm_uword_pkg::uword_t'(rand_bits(64));
        w.pad      = '0;
        w.cond_sel = mbesm_uword_pkg::cond_sel_e'(rand_bits(3) % 6);
        w.cin_sel  = mbesm_uword_pkg::cin_sel_e'(rand_bits(2) % 3);
        w.seq_op   = mbesm_uword_pkg::SEQ_CONT;
        r          = 3'(rand_bits(3));
        if (r < 2) begin
            w.seq_op  = mbesm_uword_pkg::SEQ_CJP;   // Forward, inside region
            w.br_addr = 8'(a + 1 + int'(rand_bits(8) % (last - a)));
        end else if (r == 2 && lvl < 2) begin
            w.seq_op  = mbesm_uword_pkg::SEQ_CJS;
            w.br_addr = (lvl == 1 || rand_bits(1)) ? 8'(SUB2) : 8'(SUB1);
        end else if (r == 3 && lvl > 0) begin
            w.seq_op  = mbesm_uword_pkg::SEQ_CRTN;  // Early return
        end
        case (rand_bits(3))
            0, 1:    w.ydst = mbesm_uword_pkg::YD_REG;
            2, 3:    w.ydst = mbesm_uword_pkg::YD_OUT;
            4:       w.ydst = mbesm_uword_pkg::YD_UREG;
            5:       w.ydst = mbesm_uword_pkg::YD_PSHIFT;
            6:       w.ydst = mbesm_uword_pkg::YD_SHIFT;
            default: w.ydst = mbesm_uword_pkg::YD_NONE;
        endcase
        return w;
    endfunction

    task automatic build_program();
        for (int a = 0; a < mbesm_uword_pkg::USTORE_N; a++) begin
            prog[a]     = '0;                       // Unused, literal marks address
            prog[a].lit = 16'h5a00 ^ 16'(a);
        end
        for (int r = 0; r < 16; r++) begin
            prog[r] = load_word(4'(r), mbesm_uword_pkg::YD_REG);    // Whole register file
        end
        prog[16] = load_word(4'd0, mbesm_uword_pkg::YD_UREG);
        prog[17] = load_word(4'd0, mbesm_uword_pkg::YD_PSHIFT);
        prog[18] = load_word(4'd0, mbesm_uword_pkg::YD_SHIFT);
        for (int a = 19; a < MAIN_END; a++) begin
            prog[a] = body_word(a, MAIN_END, 0);
        end
        prog[MAIN_END].ydst = mbesm_uword_pkg::YD_HALT;
        for (int a = SUB1; a < SUB2 + SUB_N - 1; a++) begin
            if (a < SUB2 - 1) begin
                prog[a] = body_word(a, SUB2 - 1, 1);
            end else if (a >= SUB2) begin
                prog[a] = body_word(a, SUB2 + SUB_N - 1, 2);
            end
        end
        prog[SUB2 - 1]         = '0;                // CRTN ALWAYS ends each subroutine
        prog[SUB2 - 1].seq_op  = mbesm_uword_pkg::SEQ_CRTN;
        prog[SUB2 + SUB_N - 1] = prog[SUB2 - 1];
    endtask

    //----------------------------------------------------------------------
    // Reference model, one microword per iteration
    //----------------------------------------------------------------------
    task automatic run_model();
        logic [DW-1:0]           rf [16];
        logic [DW-1:0]           ureg, shq, d, y;
        logic [DW:0]             sum;               // Carry in top bit
        logic [6:0]              psh;
        logic [2:0]              fl;                // Z, N, C
        logic [5:0]              cv;                // Indexed by cond select
        logic                    tr0, tr1, c, cin;
        logic [7:0]              stk [$];
        int                      pc, nxt, steps;
        mbesm_uword_pkg::uword_t w;
        fl    = '0;
        tr0   = 1'b0;
        tr1   = 1'b0;
        pc    = 0;
        steps = 0;
        exp_q.delete();
        while (prog[pc].ydst != mbesm_uword_pkg::YD_HALT) begin
            w = prog[pc];
            steps++;
            if (steps > 2000) begin
                $display("Reference model did not reach the HALT word");
                $display("TEST FAILED");
                $fatal(1, "model runaway");
            end
            cv  = {tr1, tr0, fl[0], fl[1], fl[2], 1'b1};
            c   = cv[w.cond_sel] ^ w.cond_inv;
            cin = (w.cin_sel == mbesm_uword_pkg::CIN_ONE) ||
                  (w.cin_sel == mbesm_uword_pkg::CIN_COND && c);
            case (w.dsrc)
                mbesm_uword_pkg::DSRC_LIT:   d = DW'(w.lit);
                mbesm_uword_pkg::DSRC_UREG:  d = ureg;
                mbesm_uword_pkg::DSRC_SHIFT: d = shq;
                default:                     d = DW'(fl);
            endcase
            case (w.alu_op)
                mbesm_data_pkg::ALU_ADD:   sum = rf[w.ra] + d + cin;
                mbesm_data_pkg::ALU_SUB:   sum = rf[w.ra] + {1'b0, ~d} + cin;
                mbesm_data_pkg::ALU_AND:   sum = {1'b0, rf[w.ra] & d};
                mbesm_data_pkg::ALU_OR:    sum = {1'b0, rf[w.ra] | d};
                mbesm_data_pkg::ALU_XOR:   sum = {1'b0, rf[w.ra] ^ d};
                mbesm_data_pkg::ALU_PASSD: sum = {1'b0, d};
                mbesm_data_pkg::ALU_PASSA: sum = {1'b0, rf[w.ra]};
                default:                   sum = {1'b0, ~rf[w.ra]};
            endcase
            y = sum[DW-1:0];
            if (w.flag_en) fl = {y == '0, y[DW-1], sum[DW]};
            case (w.ydst)
                mbesm_uword_pkg::YD_REG:    rf[w.rb] = y;
                mbesm_uword_pkg::YD_UREG:   ureg = y;
                mbesm_uword_pkg::YD_PSHIFT: psh = y[6:0];
                mbesm_uword_pkg::YD_SHIFT:  shq = psh[6] ? y << psh[5:0] : y >> psh[5:0];
                mbesm_uword_pkg::YD_OUT:    exp_q.push_back(y);
                default: ;
            endcase
            tr0 = (w.ff_op == mbesm_uword_pkg::FF_SET_TR0) |
                  (tr0 & (w.ff_op != mbesm_uword_pkg::FF_CLR_ALL));
            tr1 = (w.ff_op == mbesm_uword_pkg::FF_SET_TR1) |
                  (tr1 & (w.ff_op != mbesm_uword_pkg::FF_CLR_ALL));
            nxt = pc + 1;
            if (c && w.seq_op == mbesm_uword_pkg::SEQ_CJP) nxt = w.br_addr;
            if (c && w.seq_op == mbesm_uword_pkg::SEQ_CJS) begin
                stk.push_back(8'(nxt));             // Return to word after call
                nxt = w.br_addr;
            end
            if (c && w.seq_op == mbesm_uword_pkg::SEQ_CRTN) begin
                nxt = (stk.size() > 0) ? int'(stk.pop_back()) : 0;
            end
            if (w.seq_op == mbesm_uword_pkg::SEQ_JZ) begin
                nxt = 0;
                stk.delete();
            end
            pc = nxt % 256;
        end
    endtask

    //----------------------------------------------------------------------
    // One program: reset, load, run to HALT, compare
    //----------------------------------------------------------------------
    task automatic run_program(input int num);
        int t;
        build_program();
        run_model();
        got_q.delete();
        @(negedge clk);
        reset = 1'b1;
        i_run = 1'b0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        for (int a = 0; a < mbesm_uword_pkg::USTORE_N; a++) begin
            @(negedge clk);
            i_load_we   = 1'b1;
            i_load_addr = 8'(a);
            i_load_word = prog[a];
        end
        @(negedge clk);
        i_load_we = 1'b0;
        i_run     = 1'b1;                           // Word 0 fetched at next edge
        t         = 0;
        while (!o_halted) begin
            @(negedge clk);
            if (o_out_valid) got_q.push_back(o_out_data);
            t++;
            if (t > 5000) begin
                $display("The core did not halt within %0d cycles", t);
                $display("TEST FAILED");
                $fatal(1, "halt timeout");
            end
        end
        for (int i = 0; i < 50; i++) begin
            @(negedge clk);
            check_value(o_halted, 1'b1, "halted level dropped");
            check_value(o_out_valid, 1'b0, "output pulse after halt");
        end
        i_run = 1'b0;
        check_value(got_q.size(), exp_q.size(), $sformatf("output count, program %0d", num));
        foreach (exp_q[i]) begin
            check_value(got_q[i], exp_q[i], $sformatf("output %0d, program %0d", i, num));
        end
    endtask

    initial begin
        reset       = 1'b1;
        i_run       = 1'b0;
        i_load_we   = 1'b0;
        i_load_addr = '0;
        i_load_word = '0;
        for (int p = 0; p < 3; p++) begin
            run_program(p);
        end
        if (i_mbesm_ucore.i_sequencer.i_seq_assert.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("Sequencer assertions failed %0d times",
                     i_mbesm_ucore.i_sequencer.i_seq_assert.fail_count);
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mbesm_ucore.f ====
hdl/mbesm_uword_pkg.sv
hdl/mbesm_data_pkg.sv
hdl/mbesm_uinstr_decode.sv
hdl/mbesm_sequencer.sv
hdl/mbesm_execute.sv
hdl/mbesm_result.sv
hdl/mbesm_ucore.sv
verif/mbesm_ucore_assert.sv
verif/mbesm_ucore_tb.sv
